// ==== rtl/cache_pkg.sv ====
package cache_pkg;

   // Data word moved between the datapath, the cache and memory
   typedef logic [31:0] word_t;

   // Byte address as issued by the datapath
   typedef logic [31:0] addr_t;

   // Tag field, address bits 31 to 6
   typedef logic [25:0] tag_t;

   // Set index, address bits 5 to 3
   typedef logic [2:0] set_idx_t;

   // Address bit 2 picks the word inside a two-word block

   localparam int SETS = 8;  // Tied to the width of set_idx_t

   // Word written with the net hit count at the end of a flush
   localparam addr_t COUNT_ADDR = 32'h0000_3100;

endpackage

// ==== rtl/dcache_array.sv ====
`timescale 1ns/100ps

module dcache_array (
   input  logic                        CLK,
   input  logic                        nRST,
   input  cache_pkg::set_idx_t         lookup_set,
   input  cache_pkg::set_idx_t         cursor_set,
   input  logic [1:0]                  way_wen,
   input  cache_pkg::tag_t             wr_tag,
   input  cache_pkg::word_t            wr_word0,
   input  cache_pkg::word_t            wr_word1,
   input  logic                        wr_dirty,
   input  logic                        wr_valid,
   input  logic                        lru_wen,
   input  logic                        lru_way,
   input  logic                        clear_all,
   output cache_pkg::tag_t  [1:0]      lk_tag,
   output logic             [1:0]      lk_valid,
   output logic             [1:0]      lk_dirty,
   output cache_pkg::word_t [1:0]      lk_word0,
   output cache_pkg::word_t [1:0]      lk_word1,
   output cache_pkg::tag_t  [1:0]      cur_tag,
   output logic             [1:0]      cur_valid,
   output logic             [1:0]      cur_dirty,
   output cache_pkg::word_t [1:0]      cur_word0,
   output cache_pkg::word_t [1:0]      cur_word1,
   output logic                        lru
);
   import cache_pkg::*;

   tag_t  tag_mem   [SETS][2];
   word_t word0_mem [SETS][2];
   word_t word1_mem [SETS][2];

   logic [SETS-1:0][1:0] valid_q;
   logic [SETS-1:0][1:0] dirty_q;
   logic [SETS-1:0]      lru_q;  // Way used most recently in each set

   always_ff @(posedge CLK)
   begin
      for (int w = 0; w < 2; w++)
      begin
         if (way_wen[w])
         begin
            tag_mem[lookup_set][w]   <= wr_tag;
            word0_mem[lookup_set][w] <= wr_word0;
            word1_mem[lookup_set][w] <= wr_word1;
         end
      end
   end

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         valid_q <= '0;
         dirty_q <= '0;
         lru_q   <= '0;
      end
      else if (clear_all)
      begin
         valid_q <= '0;
         dirty_q <= '0;
         lru_q   <= '0;
      end
      else
      begin
         for (int w = 0; w < 2; w++)
         begin
            if (way_wen[w])
            begin
               valid_q[lookup_set][w] <= wr_valid;
               dirty_q[lookup_set][w] <= wr_dirty;
            end
         end
         if (lru_wen)
            lru_q[lookup_set] <= lru_way;
      end
   end

   always_comb
   begin
      for (int w = 0; w < 2; w++)
      begin
         lk_tag[w]    = tag_mem[lookup_set][w];
         lk_word0[w]  = word0_mem[lookup_set][w];
         lk_word1[w]  = word1_mem[lookup_set][w];
         cur_tag[w]   = tag_mem[cursor_set][w];
         cur_word0[w] = word0_mem[cursor_set][w];
         cur_word1[w] = word1_mem[cursor_set][w];
      end
   end

   assign lk_valid  = valid_q[lookup_set];
   assign lk_dirty  = dirty_q[lookup_set];
   assign cur_valid = valid_q[cursor_set];
   assign cur_dirty = dirty_q[cursor_set];
   assign lru       = lru_q[lookup_set];

endmodule

// ==== rtl/dcache.sv ====
`timescale 1ns/100ps

module dcache (
   input  logic              CLK,
   input  logic              nRST,
   input  logic              dmemren,
   input  logic              dmemwen,
   input  cache_pkg::addr_t  dmemaddr,
   input  cache_pkg::word_t  dmemstore,
   input  logic              halt,
   input  cache_pkg::word_t  dload,
   input  logic              dwait,
   output cache_pkg::word_t  dmemload,
   output logic              dhit,
   output logic              flushed,
   output logic              dren,
   output logic              dwen,
   output cache_pkg::addr_t  daddr,
   output cache_pkg::word_t  dstore
);
   import cache_pkg::*;

   typedef enum logic [3:0] {
      IDLE, WB1, WB2, READ1, READ2, SCAN, FLUSH1, FLUSH2, COUNT, HALT
   } ctrl_state_t;

   ctrl_state_t        state, next_state;
   logic [3:0]         cursor, next_cursor;  // Bit 3 is the way, bits 2..0 the set
   logic signed [31:0] hit_count, next_hit_count;

   tag_t     req_tag;
   set_idx_t req_set;
   logic     req_word;
   logic     req;

   logic [1:0] way_wen;
   tag_t       wr_tag;
   word_t      wr_word0, wr_word1;
   logic       wr_dirty, wr_valid;
   logic       lru_wen, lru_way, clear_all;

   tag_t  [1:0] lk_tag, cur_tag;
   logic  [1:0] lk_valid, lk_dirty, cur_valid, cur_dirty;
   word_t [1:0] lk_word0, lk_word1, cur_word0, cur_word1;
   logic        lru;

   logic [1:0] way_match;
   logic       hit, hit_way, victim, cur_way;

   assign req_tag  = dmemaddr[31:6];
   assign req_set  = dmemaddr[5:3];
   assign req_word = dmemaddr[2];
   assign req      = dmemren || dmemwen;

   assign way_match[0] = lk_valid[0] && (lk_tag[0] == req_tag);
   assign way_match[1] = lk_valid[1] && (lk_tag[1] == req_tag);
   assign hit          = |way_match;
   assign hit_way      = way_match[1];
   assign victim       = ~lru;  // Replace the way not used last
   assign cur_way      = cursor[3];

   assign dmemload = req_word ? lk_word1[hit_way] : lk_word0[hit_way];

   dcache_array u_array (
      .CLK(CLK), .nRST(nRST),
      .lookup_set(req_set), .cursor_set(cursor[2:0]),
      .way_wen(way_wen), .wr_tag(wr_tag), .wr_word0(wr_word0), .wr_word1(wr_word1),
      .wr_dirty(wr_dirty), .wr_valid(wr_valid),
      .lru_wen(lru_wen), .lru_way(lru_way), .clear_all(clear_all),
      .lk_tag(lk_tag), .lk_valid(lk_valid), .lk_dirty(lk_dirty),
      .lk_word0(lk_word0), .lk_word1(lk_word1),
      .cur_tag(cur_tag), .cur_valid(cur_valid), .cur_dirty(cur_dirty),
      .cur_word0(cur_word0), .cur_word1(cur_word1),
      .lru(lru)
   );

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state     <= IDLE;
         cursor    <= '0;
         hit_count <= '0;
      end
      else
      begin
         state     <= next_state;
         cursor    <= next_cursor;
         hit_count <= next_hit_count;
      end
   end

   always_comb
   begin
      next_state  = state;
      next_cursor = cursor;
      case (state)
         IDLE:
            if (halt)
               next_state = SCAN;
            else if (req && !hit)
               next_state = (lk_valid[victim] && lk_dirty[victim]) ? WB1 : READ1;
         WB1:    if (!dwait) next_state = WB2;
         WB2:    if (!dwait) next_state = READ1;
         READ1:  if (!dwait) next_state = READ2;
         READ2:  if (!dwait) next_state = IDLE;
         SCAN:
            if (cur_valid[cur_way] && cur_dirty[cur_way])
               next_state = FLUSH1;
            else if (cursor == 4'hf)
               next_state = COUNT;
            else
               next_cursor = cursor + 4'd1;
         FLUSH1: if (!dwait) next_state = FLUSH2;
         FLUSH2:
            if (!dwait)
            begin
               if (cursor == 4'hf)
                  next_state = COUNT;
               else
               begin
                  next_state  = SCAN;
                  next_cursor = cursor + 4'd1;
               end
            end
         COUNT:  if (!dwait) next_state = HALT;
         HALT:
            if (!halt)
            begin
               next_state  = IDLE;
               next_cursor = '0;
            end
         default: next_state = IDLE;
      endcase
   end

   always_comb
   begin
      dhit           = 1'b0;
      flushed        = 1'b0;
      dren           = 1'b0;
      dwen           = 1'b0;
      daddr          = '0;
      dstore         = '0;
      way_wen        = '0;
      wr_tag         = lk_tag[victim];  // Untouched fields are written back as read
      wr_word0       = lk_word0[victim];
      wr_word1       = lk_word1[victim];
      wr_dirty       = lk_dirty[victim];
      wr_valid       = lk_valid[victim];
      lru_wen        = 1'b0;
      lru_way        = hit_way;
      clear_all      = 1'b0;
      next_hit_count = hit_count;
      case (state)
         IDLE:
            if (!halt && req)
            begin
               if (hit)
               begin
                  dhit           = 1'b1;
                  lru_wen        = 1'b1;
                  next_hit_count = hit_count + 32'sd1;
                  if (dmemwen)
                  begin
                     way_wen[hit_way] = 1'b1;
                     wr_tag           = req_tag;
                     wr_word0         = req_word ? lk_word0[hit_way] : dmemstore;
                     wr_word1         = req_word ? dmemstore : lk_word1[hit_way];
                     wr_dirty         = 1'b1;
                     wr_valid         = 1'b1;
                  end
               end
               else
                  next_hit_count = hit_count - 32'sd1;
            end
         WB1, WB2:
         begin
            dwen   = 1'b1;
            daddr  = {lk_tag[victim], req_set, (state == WB2), 2'b00};
            dstore = (state == WB2) ? lk_word1[victim] : lk_word0[victim];
         end
         READ1:
         begin
            dren             = 1'b1;
            daddr            = {req_tag, req_set, 3'b000};
            way_wen[victim]  = !dwait;
            wr_word0         = dload;
            wr_dirty         = 1'b0;
            wr_valid         = 1'b0;  // Line stays invalid until both words arrive
         end
         READ2:
         begin
            dren             = 1'b1;
            daddr            = {req_tag, req_set, 3'b100};
            way_wen[victim]  = !dwait;
            wr_tag           = req_tag;
            wr_word1         = dload;
            wr_dirty         = 1'b0;
            wr_valid         = 1'b1;
         end
         FLUSH1, FLUSH2:
         begin
            dwen   = 1'b1;
            daddr  = {cur_tag[cur_way], cursor[2:0], (state == FLUSH2), 2'b00};
            dstore = (state == FLUSH2) ? cur_word1[cur_way] : cur_word0[cur_way];
         end
         COUNT:
         begin
            dwen   = 1'b1;
            daddr  = COUNT_ADDR;
            dstore = word_t'(hit_count);
         end
         HALT:
         begin
            flushed = 1'b1;
            if (!halt)
            begin
               clear_all      = 1'b1;
               next_hit_count = '0;
            end
         end
         default: ;
      endcase
   end

endmodule

// ==== rtl/main_memory.sv ====
`timescale 1ns/100ps

module main_memory #(
   parameter int MEM_LATENCY    = 2,
   parameter int MEM_DEPTH_BITS = 12  // At least 12 so the counter word fits
) (
   input  logic             CLK,
   input  logic             nRST,
   input  logic             dren,
   input  logic             dwen,
   input  cache_pkg::addr_t daddr,
   input  cache_pkg::word_t dstore,
   output cache_pkg::word_t dload,
   output logic             dwait
);
   import cache_pkg::*;

   localparam int CNT_W = (MEM_LATENCY > 0) ? $clog2(MEM_LATENCY + 1) : 1;

   word_t                     mem [2**MEM_DEPTH_BITS];
   logic [CNT_W-1:0]          wait_cnt;
   logic [MEM_DEPTH_BITS-1:0] word_idx;
   logic                      req;
   logic                      done;

   assign req      = dren || dwen;
   assign word_idx = daddr[MEM_DEPTH_BITS+1:2];  // Memory is word addressed
   assign done     = req && (wait_cnt == CNT_W'(MEM_LATENCY));
   assign dwait    = req && !done;
   assign dload    = mem[word_idx];

   initial
   begin
      for (int i = 0; i < 2**MEM_DEPTH_BITS; i++)
         mem[i] = '0;
   end

   // Count wait cycles of the held request and restart after it finishes
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
         wait_cnt <= '0;
      else if (!req || done)
         wait_cnt <= '0;
      else
         wait_cnt <= wait_cnt + 1'b1;
   end

   always @(posedge CLK)
   begin
      if (done && dwen)
         mem[word_idx] <= dstore;  // Write lands on the edge that ends the wait
   end

endmodule

// ==== rtl/cache_subsystem.sv ====
`timescale 1ns/100ps

module cache_subsystem #(
   parameter int MEM_LATENCY    = 2,
   parameter int MEM_DEPTH_BITS = 12
) (
   input  logic             CLK,
   input  logic             nRST,
   input  logic             dmemren,
   input  logic             dmemwen,
   input  cache_pkg::addr_t dmemaddr,
   input  cache_pkg::word_t dmemstore,
   input  logic             halt,
   output cache_pkg::word_t dmemload,
   output logic             dhit,
   output logic             flushed
);
   import cache_pkg::*;

   logic  dren;
   logic  dwen;
   logic  dwait;
   addr_t daddr;
   word_t dstore;
   word_t dload;

   dcache u_dcache (
      .CLK(CLK), .nRST(nRST),
      .dmemren(dmemren), .dmemwen(dmemwen), .dmemaddr(dmemaddr), .dmemstore(dmemstore),
      .halt(halt), .dload(dload), .dwait(dwait),
      .dmemload(dmemload), .dhit(dhit), .flushed(flushed),
      .dren(dren), .dwen(dwen), .daddr(daddr), .dstore(dstore)
   );

   main_memory #(.MEM_LATENCY(MEM_LATENCY), .MEM_DEPTH_BITS(MEM_DEPTH_BITS)) u_memory (
      .CLK(CLK), .nRST(nRST),
      .dren(dren), .dwen(dwen), .daddr(daddr), .dstore(dstore),
      .dload(dload), .dwait(dwait)
   );

endmodule

// ==== verification/tb_cache_subsystem.sv ====
`timescale 1ns/100ps

module tb_cache_subsystem;
   import cache_pkg::*;

   localparam int MEM_LATENCY    = 2;
   localparam int MEM_DEPTH_BITS = 12;
   localparam int CLK_HALF       = 5;
   // About 80 requests of up to 4*(MEM_LATENCY+1)+4 cycles and two flushes fit with wide margin
   localparam int TIMEOUT_CYCLES = 4000;

   logic  CLK = 1'b0;
   logic  nRST;
   logic  dmemren;
   logic  dmemwen;
   logic  halt;
   addr_t dmemaddr;
   word_t dmemstore;
   word_t dmemload;
   logic  dhit;
   logic  flushed;

   logic [31:0] lfsr;
   int          cycle_count = 0;
   int          mismatches  = 0;
   int          failures    = 0;
   int          exp_count   = 0;  // Net hit count the controller should hold

   word_t mem_model [addr_t];  // Expected memory contents keyed by word address
   logic  line_valid [SETS][2];
   logic  line_dirty [SETS][2];
   tag_t  line_tag   [SETS][2];
   logic  line_mru   [SETS];

   cache_subsystem #(.MEM_LATENCY(MEM_LATENCY), .MEM_DEPTH_BITS(MEM_DEPTH_BITS)) u_dut (
      .CLK(CLK), .nRST(nRST),
      .dmemren(dmemren), .dmemwen(dmemwen), .dmemaddr(dmemaddr), .dmemstore(dmemstore),
      .halt(halt), .dmemload(dmemload), .dhit(dhit), .flushed(flushed)
   );

   always #(CLK_HALF) CLK = ~CLK;

   always @(posedge CLK)
   begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         failures++;
         $display("Timeout after %0d cycles before the tests completed", cycle_count);
         report_errors();
         $display("Simulation failed");
         $finish;
      end
   end

   // Taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic word_t random_word();
      word_t w;
      w = '0;
      for (int i = 0; i < 32; i++)
      begin
         lfsr = lfsr_step(lfsr);
         w    = {w[30:0], lfsr[0]};
      end
      return w;
   endfunction

   function automatic word_t model_word(input addr_t addr);
      return mem_model.exists(addr >> 2) ? mem_model[addr >> 2] : '0;
   endfunction

   task automatic report_errors();
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      assert (got === exp)
      else
      begin
         mismatches++;
         $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic clear_model();
      for (int s = 0; s < SETS; s++)
      begin
         line_mru[s] = 1'b0;
         for (int w = 0; w < 2; w++)
         begin
            line_valid[s][w] = 1'b0;
            line_dirty[s][w] = 1'b0;
         end
      end
      exp_count = 0;
   endtask

   task automatic cache_access(input logic is_write, input addr_t addr, input word_t wdata);
      set_idx_t s;
      tag_t     t;
      logic     hit;
      logic     way;
      int       exp_cycles;
      int       cycles;
      word_t    exp_load;
      s          = addr[5:3];
      t          = addr[31:6];
      hit        = 1'b0;
      way        = ~line_mru[s];  // Victim if the access misses
      exp_cycles = 1;
      for (int w = 0; w < 2; w++)
      begin
         if (line_valid[s][w] && line_tag[s][w] == t)
         begin
            hit = 1'b1;
            way = w[0];
         end
      end
      if (!hit)
      begin
         exp_cycles = 2 + 2 * (MEM_LATENCY + 1);  // Detect cycle and refill before the hit
         if (line_valid[s][way] && line_dirty[s][way])
            exp_cycles += 2 * (MEM_LATENCY + 1);
         line_valid[s][way] = 1'b1;
         line_dirty[s][way] = 1'b0;
         line_tag[s][way]   = t;
         exp_count--;
      end
      exp_load    = model_word(addr);
      line_mru[s] = way;
      exp_count++;
      if (is_write)
      begin
         line_dirty[s][way]   = 1'b1;
         mem_model[addr >> 2] = wdata;
      end

      @(negedge CLK);
      dmemren   = !is_write;
      dmemwen   = is_write;
      dmemaddr  = addr;
      dmemstore = wdata;
      cycles    = 1;
      #(CLK_HALF - 1);
      while (dhit !== 1'b1)
      begin
         @(negedge CLK);
         #(CLK_HALF - 1);
         cycles++;
      end
      if (!is_write)
         check_word("dmemload", dmemload, exp_load);
      check_word("dhit cycles", word_t'(cycles), word_t'(exp_cycles));
      @(negedge CLK);
      dmemren = 1'b0;
      dmemwen = 1'b0;
   endtask

   task automatic cache_write(input addr_t addr, input word_t data);
      cache_access(1'b1, addr, data);
   endtask

   task automatic cache_read(input addr_t addr);
      cache_access(1'b0, addr, '0);
   endtask

   task automatic do_halt();
      @(negedge CLK);
      halt = 1'b1;
      #(CLK_HALF - 1);
      while (flushed !== 1'b1)
      begin
         @(negedge CLK);
         #(CLK_HALF - 1);
      end
      repeat (2)
      begin
         @(negedge CLK);
         #(CLK_HALF - 1);
         check_word("flushed", word_t'(flushed), 32'h1);
      end
      @(negedge CLK);
      halt = 1'b0;
      mem_model[COUNT_ADDR >> 2] = word_t'(exp_count);
      clear_model();
      @(negedge CLK);
      check_word("flushed", word_t'(flushed), 32'h0);
   endtask

   task automatic test_reset_reads();
      cache_read(32'h0000_0000);
      cache_read(32'h0000_0004);
      cache_read(32'h0000_0000);
      cache_read(32'h0000_0a48);
   endtask

   task automatic test_write_read();
      cache_write(32'h0000_0130, random_word());
      cache_read(32'h0000_0130);
      cache_read(32'h0000_0134);
      cache_write(32'h0000_0134, random_word());
      cache_read(32'h0000_0130);
      cache_read(32'h0000_0134);
   endtask

   task automatic test_lru_eviction();
      cache_write(32'h0000_0210, random_word());  // A, B and C all map to set 2
      cache_write(32'h0000_0410, random_word());
      cache_read(32'h0000_0210);
      cache_write(32'h0000_0610, random_word());
      cache_read(32'h0000_0410);
      cache_read(32'h0000_0610);
   endtask

   task automatic test_flush();
      addr_t base;
      for (int k = 0; k < 2; k++)
      begin
         for (int s = 0; s < SETS; s++)
         begin
            base = 32'h0000_1000 + addr_t'(k * 64 + s * 8);
            cache_write(base, random_word());
            cache_write(base + 32'h4, random_word());
         end
      end
      do_halt();
      for (int k = 0; k < 2; k++)
      begin
         for (int s = 0; s < SETS; s++)
         begin
            base = 32'h0000_1000 + addr_t'(k * 64 + s * 8);
            cache_read(base);
            cache_read(base + 32'h4);
         end
      end
   endtask

   task automatic test_count();
      cache_read(COUNT_ADDR);
      do_halt();
      cache_read(COUNT_ADDR);
   endtask

   initial
   begin
      nRST      = 1'b0;
      dmemren   = 1'b0;
      dmemwen   = 1'b0;
      dmemaddr  = '0;
      dmemstore = '0;
      halt      = 1'b0;
      lfsr      = 32'h0769443a;
      clear_model();
      repeat (8) @(negedge CLK);
      nRST = 1'b1;
      @(negedge CLK);
      check_word("dhit", word_t'(dhit), 32'h0);
      check_word("flushed", word_t'(flushed), 32'h0);
      check_word("dren", word_t'(u_dut.dren), 32'h0);
      check_word("dwen", word_t'(u_dut.dwen), 32'h0);
      test_reset_reads();
      test_write_read();
      test_lru_eviction();
      test_flush();
      test_count();
      report_errors();
      if (mismatches == 0 && failures == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== src.f ====
rtl/cache_pkg.sv
rtl/dcache_array.sv
rtl/dcache.sv
rtl/main_memory.sv
rtl/cache_subsystem.sv
verification/tb_cache_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_cache_subsystem
RTL_TOP   ?= cache_subsystem
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
